// ==== eeprom_range_params.svh ====
`ifndef EEPROM_RANGE_PARAMS_SVH
`define EEPROM_RANGE_PARAMS_SVH

// Seven-bit slave address of the EEPROM on the bus.
`define EEPROM_DEVICE_ID 7'b1010001

// Word address that receives the max minus min result.
`define EEPROM_RESULT_ADDR 8'd255

`define EEPROM_DATA_W 8

// System clocks per quarter of an SCL period.
`define I2C_QUARTER_CYCLES 2

`endif

// ==== eeprom_range_pkg.sv ====
`include "eeprom_range_params.svh"

package eeprom_range_pkg;

	// One EEPROM word, used for both addresses and data.
	typedef logic [`EEPROM_DATA_W-1:0] byte_t;

	typedef enum logic [1:0]
	{
		BIT_START,
		BIT_STOP,
		BIT_WRITE,
		BIT_READ
	} bit_cmd_e;

	typedef enum logic [1:0]
	{
		OP_START,
		OP_STOP,
		OP_WRITE,
		OP_READ
	} byte_op_e;

	typedef enum logic [3:0]
	{
		IDLE, RD_START, RD_DEV_W, RD_WORD, RD_RESTART, RD_DEV_R, RD_DATA, RD_STOP,
		WR_START, WR_DEV_W, WR_WORD, WR_DATA, WR_STOP, DONE
	} scan_state_e;

endpackage

// ==== i2c_bit_engine.sv ====
`timescale 1ns/1ns
`include "eeprom_range_params.svh"

module i2c_bit_engine
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_bit_valid,
	input  eeprom_range_pkg::bit_cmd_e  i_bit_cmd,
	input  logic                        i_tx_bit,
	input  logic                        i_sda,
	output logic                        o_bit_done,
	output logic                        o_rx_bit,
	output logic                        o_scl,
	output logic                        o_sda_out,
	output logic                        o_sda_oe
);
	import eeprom_range_pkg::*;

	localparam int TIMER_W = $clog2(`I2C_QUARTER_CYCLES + 1);

	logic               busy;
	logic [TIMER_W-1:0] timer;
	logic [1:0]         phase;
	logic               quarter_end;
	bit_cmd_e           cmd;
	logic               tx_bit;

	// Pad pattern {scl, sda_oe, sda_out} for one quarter of a command.
	function automatic logic [2:0] pad_pattern(input bit_cmd_e c, input logic [1:0] ph,
		input logic b);
		logic scl;
		logic oe;
		logic sda;
		scl = (ph == 2'd1) || (ph == 2'd2); // SCL is high in the middle quarters.
		oe = 1'b1;
		sda = b;
		case (c)
			BIT_START:
			begin
				sda = (ph < 2'd2); // SDA falls while SCL is high.
			end
			BIT_STOP:
			begin
				scl = (ph != 2'd0);
				oe = (ph != 2'd3); // Release the line once the STOP is on the bus.
				sda = (ph >= 2'd2);
			end
			BIT_READ:
			begin
				oe = 1'b0;
				sda = 1'b1;
			end
			default:
			begin
				sda = b;
			end
		endcase
		return {scl, oe, sda};
	endfunction

	assign quarter_end = (timer == TIMER_W'(`I2C_QUARTER_CYCLES - 1));
	assign o_bit_done = busy && (phase == 2'd3) && quarter_end;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			timer <= '0;
			phase <= 2'd0;
			o_scl <= 1'b1;
			o_sda_oe <= 1'b0;
			o_sda_out <= 1'b1;
		end
		else if (!busy)
		begin
			if (i_bit_valid)
			begin
				busy <= 1'b1;
				timer <= '0;
				phase <= 2'd0;
				{o_scl, o_sda_oe, o_sda_out} <= pad_pattern(i_bit_cmd, 2'd0, i_tx_bit);
			end
		end
		else if (quarter_end)
		begin
			timer <= '0;
			phase <= phase + 2'd1;
			if (phase == 2'd3)
			begin
				busy <= 1'b0; // Pads hold their last level until the next command.
			end
			else
			begin
				{o_scl, o_sda_oe, o_sda_out} <= pad_pattern(cmd, phase + 2'd1, tx_bit);
			end
		end
		else
		begin
			timer <= timer + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy && i_bit_valid)
		begin
			cmd <= i_bit_cmd;
			tx_bit <= i_tx_bit;
		end
		if (busy && (cmd == BIT_READ) && (phase == 2'd1) && quarter_end)
		begin
			o_rx_bit <= i_sda; // Sample point at the end of quarter 1.
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (rst) i_bit_valid |-> !busy);

endmodule

// ==== i2c_byte_engine.sv ====
`timescale 1ns/1ns
`include "eeprom_range_params.svh"

module i2c_byte_engine
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_byte_valid,
	input  eeprom_range_pkg::byte_op_e  i_byte_op,
	input  eeprom_range_pkg::byte_t     i_tx_byte,
	input  logic                        i_send_ack,
	input  logic                        i_bit_done,
	input  logic                        i_rx_bit,
	output logic                        o_byte_done,
	output eeprom_range_pkg::byte_t     o_rx_byte,
	output logic                        o_bit_valid,
	output eeprom_range_pkg::bit_cmd_e  o_bit_cmd,
	output logic                        o_tx_bit
);
	import eeprom_range_pkg::*;

	// Bit index of the ninth bit, the ACK slot.
	localparam logic [3:0] ACK_IDX = 4'(`EEPROM_DATA_W);

	logic       busy;
	logic [3:0] idx;
	byte_op_e   op;
	byte_t      shreg;
	logic       ack_level;
	logic       last_bit;

	assign last_bit = (op == OP_START) || (op == OP_STOP) || (idx == ACK_IDX);
	assign o_byte_done = busy && i_bit_done && last_bit;
	assign o_rx_byte = shreg;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			idx <= 4'd0;
			o_bit_valid <= 1'b0;
		end
		else
		begin
			o_bit_valid <= 1'b0;
			if (!busy)
			begin
				if (i_byte_valid)
				begin
					busy <= 1'b1;
					idx <= 4'd0;
					o_bit_valid <= 1'b1;
				end
			end
			else if (i_bit_done)
			begin
				if (last_bit)
				begin
					busy <= 1'b0;
				end
				else
				begin
					idx <= idx + 4'd1;
					o_bit_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!busy && i_byte_valid)
		begin
			op <= i_byte_op;
			shreg <= i_tx_byte;
			ack_level <= !i_send_ack; // ACK is a low level, NACK a high one.
			o_tx_bit <= i_tx_byte[`EEPROM_DATA_W-1];
			case (i_byte_op)
				OP_START: o_bit_cmd <= BIT_START;
				OP_STOP:  o_bit_cmd <= BIT_STOP;
				OP_WRITE: o_bit_cmd <= BIT_WRITE;
				default:  o_bit_cmd <= BIT_READ;
			endcase
		end
		else if (busy && i_bit_done && !last_bit)
		begin
			// One shift serves both directions, MSB first.
			shreg <= {shreg[`EEPROM_DATA_W-2:0], i_rx_bit};
			o_tx_bit <= shreg[`EEPROM_DATA_W-2];
			if (idx == ACK_IDX - 4'd1)
			begin
				o_bit_cmd <= (op == OP_WRITE) ? BIT_READ : BIT_WRITE;
				o_tx_bit <= ack_level;
			end
		end
	end

endmodule

// ==== range_tracker.sv ====
`timescale 1ns/1ns

module range_tracker
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_clear,
	input  logic                     i_sample_valid,
	input  eeprom_range_pkg::byte_t  i_sample,
	output eeprom_range_pkg::byte_t  o_diff
);
	import eeprom_range_pkg::*;

	byte_t min_val;
	byte_t max_val;
	byte_t next_min;
	byte_t next_max;
	logic  have_sample;

	always_comb
	begin
		next_min = min_val;
		next_max = max_val;
		if (!have_sample || (i_sample < min_val))
			next_min = i_sample;
		if (!have_sample || (i_sample > max_val))
			next_max = i_sample;
	end

	always_ff @(posedge clk)
	begin
		if (rst || i_clear)
		begin
			have_sample <= 1'b0;
			o_diff <= '0;
		end
		else if (i_sample_valid)
		begin
			have_sample <= 1'b1;
			o_diff <= next_max - next_min; // Built from the new extremes, so no extra cycle.
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_sample_valid)
		begin
			min_val <= next_min;
			max_val <= next_max;
		end
	end

	a_min_le_max: assert property (@(posedge clk) disable iff (rst)
		have_sample |-> min_val <= max_val);

endmodule

// ==== scan_sequencer.sv ====
`timescale 1ns/1ns
`include "eeprom_range_params.svh"

module scan_sequencer
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        i_start,
	input  eeprom_range_pkg::byte_t     i_first_addr,
	input  eeprom_range_pkg::byte_t     i_last_addr,
	input  logic                        i_byte_done,
	input  eeprom_range_pkg::byte_t     i_rx_byte,
	input  eeprom_range_pkg::byte_t     i_diff,
	output logic                        o_byte_valid,
	output eeprom_range_pkg::byte_op_e  o_byte_op,
	output eeprom_range_pkg::byte_t     o_tx_byte,
	output logic                        o_send_ack,
	output logic                        o_clear,
	output logic                        o_sample_valid,
	output eeprom_range_pkg::byte_t     o_sample,
	output logic                        o_busy,
	output logic                        o_done,
	output eeprom_range_pkg::byte_t     o_max_diff
);
	import eeprom_range_pkg::*;

	localparam byte_t DEV_WRITE = {`EEPROM_DEVICE_ID, 1'b0};
	localparam byte_t DEV_READ = {`EEPROM_DEVICE_ID, 1'b1};

	scan_state_e state;
	byte_t       cur_addr;
	byte_t       last_addr;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			o_byte_valid <= 1'b0;
			o_clear <= 1'b0;
			o_sample_valid <= 1'b0;
			o_busy <= 1'b0;
			o_done <= 1'b0;
			o_max_diff <= '0;
		end
		else
		begin
			o_byte_valid <= 1'b0;
			o_clear <= 1'b0;
			o_sample_valid <= 1'b0;
			o_done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (i_start)
					begin
						cur_addr <= i_first_addr;
						last_addr <= i_last_addr;
						o_busy <= 1'b1;
						o_clear <= 1'b1;
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_START;
						state <= RD_START;
					end
				end
				RD_START, WR_START:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_WRITE;
						o_tx_byte <= DEV_WRITE;
						state <= (state == RD_START) ? RD_DEV_W : WR_DEV_W;
					end
				end
				RD_DEV_W, WR_DEV_W:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_WRITE;
						o_tx_byte <= (state == RD_DEV_W) ? cur_addr : `EEPROM_RESULT_ADDR;
						state <= (state == RD_DEV_W) ? RD_WORD : WR_WORD;
					end
				end
				RD_WORD:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_START; // Repeated START turns the bus around.
						state <= RD_RESTART;
					end
				end
				RD_RESTART:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_WRITE;
						o_tx_byte <= DEV_READ;
						state <= RD_DEV_R;
					end
				end
				RD_DEV_R:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_READ;
						o_send_ack <= (cur_addr != last_addr);
						state <= RD_DATA;
					end
				end
				RD_DATA:
				begin
					if (i_byte_done)
					begin
						o_sample_valid <= 1'b1;
						o_sample <= i_rx_byte;
						o_byte_valid <= 1'b1;
						if (cur_addr == last_addr)
						begin
							o_byte_op <= OP_STOP;
							state <= RD_STOP;
						end
						else
						begin
							// The EEPROM advances its own pointer in a sequential read.
							cur_addr <= cur_addr + 1'b1;
							o_byte_op <= OP_READ;
							o_send_ack <= (byte_t'(cur_addr + 1'b1) != last_addr);
						end
					end
				end
				RD_STOP:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_START;
						state <= WR_START;
					end
				end
				WR_WORD:
				begin
					if (i_byte_done)
					begin
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_WRITE;
						o_tx_byte <= i_diff;
						state <= WR_DATA;
					end
				end
				WR_DATA:
				begin
					if (i_byte_done)
					begin
						o_max_diff <= i_diff;
						o_byte_valid <= 1'b1;
						o_byte_op <= OP_STOP;
						state <= WR_STOP;
					end
				end
				WR_STOP:
				begin
					if (i_byte_done)
					begin
						o_busy <= 1'b0;
						o_done <= 1'b1;
						state <= DONE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	a_range_order: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE && i_start) |-> (i_last_addr >= i_first_addr));

endmodule

// ==== eeprom_range_top.sv ====
`timescale 1ns/1ns

module eeprom_range_top
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_start,
	input  eeprom_range_pkg::byte_t  i_first_addr,
	input  eeprom_range_pkg::byte_t  i_last_addr,
	input  logic                     i_sda,
	output logic                     o_scl,
	output logic                     o_sda_out,
	output logic                     o_sda_oe,
	output logic                     o_busy,
	output logic                     o_done,
	output eeprom_range_pkg::byte_t  o_max_diff
);
	import eeprom_range_pkg::*;

	logic     byte_valid;
	byte_op_e byte_op;
	byte_t    tx_byte;
	logic     send_ack;
	logic     byte_done;
	byte_t    rx_byte;
	logic     bit_valid;
	bit_cmd_e bit_cmd;
	logic     tx_bit;
	logic     bit_done;
	logic     rx_bit;
	logic     clear;
	logic     sample_valid;
	byte_t    sample;
	byte_t    diff_val;

	scan_sequencer u_scan_sequencer
	(
		.clk            (clk),
		.rst            (rst),
		.i_start        (i_start),
		.i_first_addr   (i_first_addr),
		.i_last_addr    (i_last_addr),
		.i_byte_done    (byte_done),
		.i_rx_byte      (rx_byte),
		.i_diff         (diff_val),
		.o_byte_valid   (byte_valid),
		.o_byte_op      (byte_op),
		.o_tx_byte      (tx_byte),
		.o_send_ack     (send_ack),
		.o_clear        (clear),
		.o_sample_valid (sample_valid),
		.o_sample       (sample),
		.o_busy         (o_busy),
		.o_done         (o_done),
		.o_max_diff     (o_max_diff)
	);

	i2c_byte_engine u_i2c_byte_engine
	(
		.clk          (clk),
		.rst          (rst),
		.i_byte_valid (byte_valid),
		.i_byte_op    (byte_op),
		.i_tx_byte    (tx_byte),
		.i_send_ack   (send_ack),
		.i_bit_done   (bit_done),
		.i_rx_bit     (rx_bit),
		.o_byte_done  (byte_done),
		.o_rx_byte    (rx_byte),
		.o_bit_valid  (bit_valid),
		.o_bit_cmd    (bit_cmd),
		.o_tx_bit     (tx_bit)
	);

	i2c_bit_engine u_i2c_bit_engine
	(
		.clk         (clk),
		.rst         (rst),
		.i_bit_valid (bit_valid),
		.i_bit_cmd   (bit_cmd),
		.i_tx_bit    (tx_bit),
		.i_sda       (i_sda),
		.o_bit_done  (bit_done),
		.o_rx_bit    (rx_bit),
		.o_scl       (o_scl),
		.o_sda_out   (o_sda_out),
		.o_sda_oe    (o_sda_oe)
	);

	range_tracker u_range_tracker
	(
		.clk            (clk),
		.rst            (rst),
		.i_clear        (clear),
		.i_sample_valid (sample_valid),
		.i_sample       (sample),
		.o_diff         (diff_val)
	);

endmodule

// ==== tb_eeprom_model.sv ====
`timescale 1ns/1ns
`include "eeprom_range_params.svh"

module tb_eeprom_model
(
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_scl,
	input  logic                     i_sda,
	input  eeprom_range_pkg::byte_t  i_last_addr,
	input  logic                     i_load_en,
	input  eeprom_range_pkg::byte_t  i_load_addr,
	input  eeprom_range_pkg::byte_t  i_load_data,
	input  eeprom_range_pkg::byte_t  i_peek_addr,
	output eeprom_range_pkg::byte_t  o_peek_data,
	output logic                     o_sda_low,
	output int                       o_error_count
);
	import eeprom_range_pkg::*;

	typedef enum logic [2:0]
	{
		M_IDLE,
		M_DEV,
		M_WORD,
		M_WDATA,
		M_RDATA
	} mode_e;

	byte_t      mem [0:255];
	mode_e      mode;
	logic       scl_q;
	logic       sda_q;
	logic [3:0] bit_cnt;
	byte_t      shreg;
	byte_t      tx_byte;
	byte_t      ptr;
	byte_t      ptr_next;
	logic       skip_fall;
	logic       repeated;
	logic       read_mode;
	logic       master_ack;
	logic       scl_rise;
	logic       scl_fall;
	logic       start_cond;
	logic       stop_cond;

	// Bus events are seen one clock late, since both lines are sampled on clk.
	assign scl_rise = !scl_q && i_scl;
	assign scl_fall = scl_q && !i_scl;
	assign start_cond = scl_q && i_scl && sda_q && !i_sda;
	assign stop_cond = scl_q && i_scl && !sda_q && i_sda;
	assign ptr_next = ptr + 8'd1;
	assign o_peek_data = mem[i_peek_addr];

	always @(posedge clk)
	begin
		if (i_load_en)
			mem[i_load_addr] <= i_load_data;
		if (rst)
		begin
			mode <= M_IDLE;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			bit_cnt <= 4'd0;
			skip_fall <= 1'b0;
			repeated <= 1'b0;
			o_sda_low <= 1'b0;
			o_error_count <= 0;
		end
		else
		begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (start_cond || stop_cond)
			begin
				// SDA may only move under a high SCL between bytes.
				assert (mode == M_IDLE || bit_cnt == 4'd0) else
				begin
					$display("Error: SDA changed while SCL was high in the middle of a byte.");
					o_error_count <= o_error_count + 1;
				end
				o_sda_low <= 1'b0;
				bit_cnt <= 4'd0;
				mode <= start_cond ? M_DEV : M_IDLE;
				repeated <= (mode != M_IDLE);
				skip_fall <= start_cond; // The START itself ends with one SCL fall.
			end
			else if (mode != M_IDLE && scl_rise)
			begin
				if (bit_cnt < 4'd8)
					shreg <= {shreg[6:0], i_sda};
				else if (mode == M_RDATA)
				begin
					master_ack <= !i_sda;
					assert (!i_sda == (ptr != i_last_addr)) else
					begin
						$display("Error: master ACK bit at address %h got %h expected %h",
							ptr, !i_sda, (ptr != i_last_addr));
						o_error_count <= o_error_count + 1;
					end
				end
			end
			else if (mode != M_IDLE && scl_fall)
			begin
				if (skip_fall)
					skip_fall <= 1'b0;
				else if (bit_cnt < 4'd7)
				begin
					bit_cnt <= bit_cnt + 4'd1;
					if (mode == M_RDATA)
						o_sda_low <= !tx_byte[6 - bit_cnt];
				end
				else if (bit_cnt == 4'd7)
				begin
					bit_cnt <= 4'd8;
					case (mode)
						M_DEV:
						begin
							assert (shreg == {`EEPROM_DEVICE_ID, repeated}) else
							begin
								$display("Error: device byte got %h expected %h",
									shreg, {`EEPROM_DEVICE_ID, repeated});
								o_error_count <= o_error_count + 1;
							end
							read_mode <= shreg[0];
							o_sda_low <= (shreg[7:1] == `EEPROM_DEVICE_ID);
							if (shreg[7:1] != `EEPROM_DEVICE_ID)
								mode <= M_IDLE;
						end
						M_WORD:
						begin
							ptr <= shreg;
							o_sda_low <= 1'b1;
						end
						M_WDATA:
						begin
							mem[ptr] <= shreg;
							ptr <= ptr_next;
							o_sda_low <= 1'b1;
						end
						default:
						begin
							o_sda_low <= 1'b0; // Hand the line to the master for its ACK.
						end
					endcase
				end
				else
				begin
					bit_cnt <= 4'd0;
					o_sda_low <= 1'b0;
					case (mode)
						M_DEV:
						begin
							if (read_mode)
							begin
								mode <= M_RDATA;
								tx_byte <= mem[ptr];
								o_sda_low <= !mem[ptr][7];
							end
							else
								mode <= M_WORD;
						end
						M_WORD:
							mode <= M_WDATA;
						M_RDATA:
						begin
							if (master_ack)
							begin
								ptr <= ptr_next;
								tx_byte <= mem[ptr_next];
								o_sda_low <= !mem[ptr_next][7];
							end
							else
								mode <= M_IDLE;
						end
						default:
						begin
							mode <= mode;
						end
					endcase
				end
			end
		end
	end

endmodule

// ==== tb_eeprom_range.sv ====
`timescale 1ns/1ns
`include "eeprom_range_params.svh"

module tb_eeprom_range;
	import eeprom_range_pkg::*;

	localparam int RUNS = 5;
	localparam int BYTE_CYCLES = 36 * 4 * `I2C_QUARTER_CYCLES;
	localparam byte_t RUN_FIRST [RUNS] = '{8'd10, 8'd7, 8'd200, 8'd0, 8'd128};
	localparam byte_t RUN_LAST [RUNS] = '{8'd25, 8'd7, 8'd254, 8'd3, 8'd140};

	logic  clk;
	logic  rst;
	logic  start;
	byte_t first_addr;
	byte_t last_addr;
	logic  sda;
	logic  scl;
	logic  sda_out;
	logic  sda_oe;
	logic  busy;
	logic  done;
	byte_t max_diff;
	logic  model_sda_low;
	logic  load_en;
	byte_t load_addr;
	byte_t load_data;
	byte_t peek_addr;
	byte_t peek_data;
	int    model_errors;
	byte_t exp_mem [0:255];
	int    errors = 0;
	int    checks = 0;
	int    done_count = 0;
	int    cycle_count;
	int    timeout_limit;

	// The bus is open drain, so a low level from either side wins.
	assign sda = (sda_oe ? sda_out : 1'b1) && !model_sda_low;

	eeprom_range_top u_eeprom_range_top
	(
		.clk          (clk),
		.rst          (rst),
		.i_start      (start),
		.i_first_addr (first_addr),
		.i_last_addr  (last_addr),
		.i_sda        (sda),
		.o_scl        (scl),
		.o_sda_out    (sda_out),
		.o_sda_oe     (sda_oe),
		.o_busy       (busy),
		.o_done       (done),
		.o_max_diff   (max_diff)
	);

	tb_eeprom_model u_eeprom_model
	(
		.clk           (clk),
		.rst           (rst),
		.i_scl         (scl),
		.i_sda         (sda),
		.i_last_addr   (last_addr),
		.i_load_en     (load_en),
		.i_load_addr   (load_addr),
		.i_load_data   (load_data),
		.i_peek_addr   (peek_addr),
		.o_peek_data   (peek_data),
		.o_sda_low     (model_sda_low),
		.o_error_count (model_errors)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		if (!rst && done)
			done_count <= done_count + 1;
	end

	a_done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		errors++;
		$display("Error: o_done stayed high for more than one cycle.");
	end

	a_done_on_busy_fall: assert property (@(posedge clk) disable iff (rst)
		done |-> ($past(busy) && !busy))
	else
	begin
		errors++;
		$display("Error: o_busy did not fall together with o_done.");
	end

	a_busy_fall_has_done: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
	else
	begin
		errors++;
		$display("Error: o_busy fell without an o_done pulse.");
	end

	a_start_sets_busy: assert property (@(posedge clk) disable iff (rst)
		(start && !busy && !done) |=> busy)
	else
	begin
		errors++;
		$display("Error: o_busy did not rise after an accepted start.");
	end

	a_bus_released: assert property (@(posedge clk) disable iff (rst) !busy |-> (scl && !sda_oe))
	else
	begin
		errors++;
		$display("Error: SCL or SDA not released while the DUT is idle.");
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Largest minus smallest byte of the reference memory over the range.
	function automatic byte_t expected_range(input byte_t lo_addr, input byte_t hi_addr);
		byte_t lo;
		byte_t hi;
		int    a;
		lo = exp_mem[lo_addr];
		hi = exp_mem[lo_addr];
		for (a = lo_addr; a <= hi_addr; a++)
		begin
			if (exp_mem[a] < lo)
				lo = exp_mem[a];
			if (exp_mem[a] > hi)
				hi = exp_mem[a];
		end
		return hi - lo;
	endfunction

	function automatic int run_budget();
		int total;
		int r;
		total = 0;
		for (r = 0; r < RUNS; r++)
			total += BYTE_CYCLES * (int'(RUN_LAST[r]) - int'(RUN_FIRST[r]) + 1 + 8);
		return total + 256 + 16 + 2000; // Preload, reset and gaps between runs.
	endfunction

	task automatic value_error(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		errors++;
		$display("Error: %s got %0h expected %0h", name, got, expected);
	endtask

	task automatic finish_run();
		$display("Checks: %0d, testbench errors: %0d, model errors: %0d",
			checks, errors, model_errors);
		if (errors == 0 && model_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic check_idle_pads();
		@(posedge clk);
		checks += 5;
		assert (scl === 1'b1) else value_error("o_scl", scl, 1);
		assert (sda_oe === 1'b0) else value_error("o_sda_oe", sda_oe, 0);
		assert (busy === 1'b0) else value_error("o_busy", busy, 0);
		assert (done === 1'b0) else value_error("o_done", done, 0);
		assert (max_diff === 8'h00) else value_error("o_max_diff", max_diff, 0);
	endtask

	task automatic preload_memory();
		logic [31:0] state;
		int          a;
		state = 32'hbc6c189c;
		for (a = 0; a < 256; a++)
		begin
			state = next_random(state);
			exp_mem[a] = state[7:0];
			load_en <= 1'b1;
			load_addr <= byte_t'(a);
			load_data <= state[7:0];
			@(posedge clk);
		end
		load_en <= 1'b0;
	endtask

	task automatic run_scan(input byte_t lo_addr, input byte_t hi_addr, input bit strobe_busy);
		byte_t exp_diff;
		exp_diff = expected_range(lo_addr, hi_addr);
		first_addr <= lo_addr;
		last_addr <= hi_addr;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		if (strobe_busy)
		begin
			repeat (40) @(posedge clk);
			start <= 1'b1; // A scan is running, so this strobe is ignored.
			@(posedge clk);
			start <= 1'b0;
		end
		do
		begin
			@(posedge clk);
		end
		while (!done);
		checks += 2;
		assert (max_diff == exp_diff) else value_error("o_max_diff", max_diff, exp_diff);
		assert (peek_data == exp_diff) else value_error("eeprom[ff]", peek_data, exp_diff);
		repeat (20) @(posedge clk);
	endtask

	// Watchdog.
	initial
	begin
		cycle_count = 0;
		timeout_limit = run_budget();
		while (cycle_count < timeout_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		errors++;
		$display("Timeout after %0d cycles, the DUT never finished all scans.", cycle_count);
		finish_run();
	end

	initial
	begin
		int r;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		first_addr = '0;
		last_addr = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		peek_addr = `EEPROM_RESULT_ADDR;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		check_idle_pads();
		preload_memory();
		for (r = 0; r < RUNS; r++)
			run_scan(RUN_FIRST[r], RUN_LAST[r], r == 0);
		repeat (20) @(posedge clk);
		checks++;
		assert (done_count == RUNS) else value_error("o_done count", done_count, RUNS);
		finish_run();
	end

endmodule

// ==== eeprom_range.f ====
+incdir+.
eeprom_range_pkg.sv
i2c_bit_engine.sv
i2c_byte_engine.sv
range_tracker.sv
scan_sequencer.sv
eeprom_range_top.sv
tb_eeprom_model.sv
tb_eeprom_range.sv
